/* logic/post_consts.svh */
`ifndef POST_CONSTS_SVH
`define POST_CONSTS_SVH

// beat geometry
`define POST_LANES         8
`define POST_INTER_W       16    // intermediate lane and bias word
`define POST_ACT_W         8     // truncated activation
`define POST_OUT_LANE_W    16    // sign-extended output lane

// fixed point shifts
`define POST_FRAC_SHIFT    4
`define POST_LEAKY_SHIFT   6     // negative slope of 1/64

`define POST_BIAS_DEPTH    512

// output fifo, afull leaves room for beats still in the pipe
`define POST_FIFO_DEPTH    16
`define POST_FIFO_AFULL    10

`define POST_CFG_WORDS     3

`endif

/* logic/post_pkg.sv */
`include "post_consts.svh"

package post_pkg;

	// controller states, also shown on post_status
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		LOAD_BIAS = 2'd1,
		WORK      = 2'd2
	} post_state_e;

	typedef logic signed [`POST_INTER_W-1:0] inter_t;
	typedef logic signed [`POST_ACT_W-1:0] act_t;

	// one beat, lane k at index k
	typedef inter_t lanes_t [`POST_LANES];

endpackage

/* logic/post_ctrl.sv */
`include "post_consts.svh"

module post_ctrl (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  cfg_valid,
	input  logic [31:0]           cfg_data,
	input  logic                  bias_valid,
	input  logic                  bias_load_done,
	input  logic                  seq_done,
	input  logic                  fifo_afull,
	output logic                  cfg_ready,
	output logic                  bias_ready,
	output logic                  in_ready,
	output post_pkg::post_state_e state,
	output logic                  row_filter,
	output logic                  relu_en,
	output logic                  sample_en,
	output logic                  bias_en,
	output logic                  relu_leaky,
	output logic [15:0]           o_ch,
	output logic [11:0]           img_h,
	output logic [11:0]           img_w,
	output logic [15:0]           total_len,
	output logic [15:0]           chout_len,
	output logic                  start
);

	logic [1:0] cfg_cnt;
	logic cfg_fire;

	assign cfg_ready = state == post_pkg::IDLE;
	assign bias_ready = state == post_pkg::LOAD_BIAS;
	assign in_ready = state == post_pkg::WORK && !fifo_afull;	// stall before fifo fills
	assign cfg_fire = cfg_valid && cfg_ready;
	assign start = cfg_fire && cfg_cnt == 2'(`POST_CFG_WORDS - 1);	// last config word

	// field capture, one word per handshake
	always_ff @(posedge clk) begin
		if (cfg_fire) begin
			case (cfg_cnt)
				2'd0: begin
					{relu_leaky, bias_en, sample_en, relu_en, row_filter} <= cfg_data[4:0];
					o_ch <= cfg_data[23:8];
				end
				2'd1: begin
					img_h <= cfg_data[23:12];
					img_w <= cfg_data[11:0];
				end
				2'd2: begin
					total_len <= cfg_data[31:16];
					chout_len <= cfg_data[15:0];
				end
				default: begin
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= post_pkg::IDLE;
			cfg_cnt <= '0;
		end else begin
			if (cfg_fire)
				cfg_cnt <= start ? 2'd0 : cfg_cnt + 2'd1;
			case (state)
				post_pkg::IDLE: begin
					if (start)
						state <= post_pkg::LOAD_BIAS;
				end
				post_pkg::LOAD_BIAS: begin
					if (bias_valid && bias_load_done)	// o_ch-th word taken
						state <= post_pkg::WORK;
				end
				post_pkg::WORK: begin
					if (seq_done)
						state <= post_pkg::IDLE;
				end
				default: state <= post_pkg::IDLE;
			endcase
		end
	end

endmodule

/* logic/chan_seq.sv */
module chan_seq (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        start,
	input  logic        beat_fire,
	input  logic        row_filter,
	input  logic [11:0] img_h,
	input  logic [11:0] img_w,
	input  logic [15:0] total_len,
	input  logic [15:0] chout_len,
	output logic [15:0] chout_base,
	output logic        beat_drop,
	output logic        beat_sample_keep,
	output logic        seq_done
);

	logic [11:0] pix_cnt;
	logic signed [12:0] line_cnt;	// -1 marks the discarded line
	logic [15:0] grp_cnt;
	logic [15:0] grp_base;	// first channel of current group
	logic signed [12:0] line_first;
	logic pix_last;
	logic blk_last;
	logic line_last;
	logic grp_last;

	assign line_first = row_filter ? -13'sd1 : 13'sd0;
	assign pix_last = pix_cnt + 1 >= img_w;
	assign blk_last = chout_base + 8 >= grp_base + chout_len;
	assign line_last = line_cnt + 13'sd1 >= $signed({1'b0, img_h});
	assign grp_last = grp_cnt + 1 >= total_len;

	// tags for the beat being accepted now
	assign beat_drop = line_cnt[12];
	assign beat_sample_keep = ~pix_cnt[0] & ~line_cnt[0];
	assign seq_done = beat_fire & pix_last & blk_last & line_last & grp_last;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pix_cnt <= '0;
			line_cnt <= '0;
			grp_cnt <= '0;
			grp_base <= '0;
			chout_base <= '0;
		end else if (start) begin
			pix_cnt <= '0;
			line_cnt <= line_first;
			grp_cnt <= '0;
			grp_base <= '0;
			chout_base <= '0;
		end else if (beat_fire) begin
			if (!pix_last) begin
				pix_cnt <= pix_cnt + 12'd1;
			end else begin
				pix_cnt <= '0;
				if (!blk_last) begin
					chout_base <= chout_base + 16'd8;	// next block of 8 channels
				end else if (!line_last) begin
					line_cnt <= line_cnt + 13'sd1;
					chout_base <= grp_base;
				end else begin
					line_cnt <= line_first;
					if (!grp_last) begin
						grp_cnt <= grp_cnt + 16'd1;
						grp_base <= grp_base + chout_len;
						chout_base <= grp_base + chout_len;
					end else begin
						grp_cnt <= '0;
						grp_base <= '0;
						chout_base <= '0;
					end
				end
			end
		end
	end

endmodule

/* logic/bias_store.sv */
`include "post_consts.svh"

module bias_store (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     start,
	input  logic                     bias_we,
	input  logic [`POST_INTER_W-1:0] bias_data,
	input  logic [15:0]              o_ch,
	input  logic [15:0]              chout_base,
	output post_pkg::lanes_t         bias_lanes,
	output logic                     bias_load_done
);

	localparam int ROWS = `POST_BIAS_DEPTH / `POST_LANES;
	localparam int ROW_W = $clog2(ROWS);
	localparam int BANK_W = $clog2(`POST_LANES);

	logic [15:0] waddr;
	logic [ROW_W-1:0] wr_row;
	logic [ROW_W-1:0] rd_row;

	assign wr_row = waddr[BANK_W +: ROW_W];
	assign rd_row = chout_base[BANK_W +: ROW_W];	// chout_base / 8
	assign bias_load_done = bias_we && waddr + 16'd1 == o_ch;

	always_ff @(posedge clk) begin
		if (!rst_n || start)
			waddr <= '0;
		else if (bias_we)
			waddr <= waddr + 16'd1;
	end

	// bank k holds channels 8*row + k
	for (genvar k = 0; k < `POST_LANES; k++) begin : g_bank
		post_pkg::inter_t mem [ROWS];

		always_ff @(posedge clk) begin
			if (bias_we && waddr[BANK_W-1:0] == BANK_W'(k))
				mem[wr_row] <= bias_data;
			bias_lanes[k] <= mem[rd_row];
		end
	end

endmodule

/* logic/post_pipe.sv */
`include "post_consts.svh"

module post_pipe (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    beat_fire,
	input  logic [`POST_LANES*`POST_INTER_W-1:0]    in_data,
	input  logic                                    beat_drop,
	input  logic                                    beat_sample_keep,
	input  post_pkg::lanes_t                        bias_lanes,
	input  logic                                    bias_en,
	input  logic                                    relu_en,
	input  logic                                    relu_leaky,
	input  logic                                    sample_en,
	output logic                                    wr_en,
	output logic [`POST_LANES*`POST_OUT_LANE_W-1:0] wr_data
);

	localparam post_pkg::inter_t ACT_MAX = post_pkg::inter_t'(2 ** (`POST_ACT_W - 1) - 1);
	localparam post_pkg::inter_t ACT_MIN = -ACT_MAX - 1;

	logic s1_valid;
	logic s2_valid;
	logic s3_valid;
	logic s1_keep;
	logic s2_keep;
	logic s3_keep;
	post_pkg::lanes_t s1_data;
	post_pkg::lanes_t s2_data;
	post_pkg::lanes_t s3_data;

	// shift, clamp to act_t, sign extend to an output lane
	function automatic logic [`POST_OUT_LANE_W-1:0] trunc_lane(input post_pkg::inter_t v);
		post_pkg::inter_t sh;
		post_pkg::act_t a;
		sh = v >>> `POST_FRAC_SHIFT;
		if (sh > ACT_MAX)
			a = post_pkg::act_t'(ACT_MAX);
		else if (sh < ACT_MIN)
			a = post_pkg::act_t'(ACT_MIN);
		else
			a = sh[`POST_ACT_W-1:0];
		return {{(`POST_OUT_LANE_W - `POST_ACT_W){a[`POST_ACT_W-1]}}, a};
	endfunction

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
			s3_valid <= 1'b0;
			wr_en <= 1'b0;
		end else begin
			s1_valid <= beat_fire & ~beat_drop;	// first line of a group goes here
			s2_valid <= s1_valid;
			s3_valid <= s2_valid;
			wr_en <= s3_valid & (s3_keep | ~sample_en);
		end
	end

	// bias_lanes arrives one cycle after accept, lined up with s1
	always_ff @(posedge clk) begin
		s1_keep <= beat_sample_keep;
		s2_keep <= s1_keep;
		s3_keep <= s2_keep;
		for (int k = 0; k < `POST_LANES; k++) begin
			s1_data[k] <= in_data[k*`POST_INTER_W +: `POST_INTER_W];
			s2_data[k] <= bias_en ? s1_data[k] + bias_lanes[k] : s1_data[k];
			if (!relu_en || s2_data[k] >= 0)
				s3_data[k] <= s2_data[k];
			else if (relu_leaky)
				s3_data[k] <= s2_data[k] >>> `POST_LEAKY_SHIFT;	// sign fill
			else
				s3_data[k] <= '0;
			wr_data[k*`POST_OUT_LANE_W +: `POST_OUT_LANE_W] <= trunc_lane(s3_data[k]);
		end
	end

endmodule

/* logic/out_fifo.sv */
`include "post_consts.svh"

module out_fifo (
	input  logic                                    clk,
	input  logic                                    rst_n,
	input  logic                                    wr_en,
	input  logic [`POST_LANES*`POST_OUT_LANE_W-1:0] wr_data,
	input  logic                                    rd_en,
	output logic                                    rd_valid,
	output logic [`POST_LANES*`POST_OUT_LANE_W-1:0] rd_data,
	output logic                                    afull
);

	localparam int DATA_W = `POST_LANES * `POST_OUT_LANE_W;
	localparam int PTR_W = $clog2(`POST_FIFO_DEPTH);

	logic [DATA_W-1:0] mem [`POST_FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0] count;
	logic push;
	logic pop;

	assign push = wr_en && count != (PTR_W + 1)'(`POST_FIFO_DEPTH);
	assign pop = rd_en && rd_valid;
	assign rd_valid = count != '0;	// head word shown without a read
	assign rd_data = mem[rd_ptr];
	assign afull = count >= (PTR_W + 1)'(`POST_FIFO_AFULL);

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= wr_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;	// wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + push - pop;
		end
	end

endmodule

/* logic/post_process.sv */
`include "post_consts.svh"

module post_process (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  logic                                      cfg_valid,
	output logic                                      cfg_ready,
	input  logic [31:0]                               cfg_data,
	input  logic                                      bias_valid,
	output logic                                      bias_ready,
	input  logic [`POST_INTER_W-1:0]                  bias_data,
	input  logic                                      in_valid,
	output logic                                      in_ready,
	input  logic [`POST_LANES*`POST_INTER_W-1:0]      in_data,
	output logic                                      post_valid,
	input  logic                                      post_ready,
	output logic [`POST_LANES*`POST_OUT_LANE_W-1:0]   post_data,
	output post_pkg::post_state_e                     post_status
);

	logic row_filter;
	logic relu_en;
	logic sample_en;
	logic bias_en;
	logic relu_leaky;
	logic [15:0] o_ch;
	logic [11:0] img_h;
	logic [11:0] img_w;
	logic [15:0] total_len;
	logic [15:0] chout_len;
	logic start;
	logic beat_fire;
	logic bias_we;
	logic bias_load_done;
	logic seq_done;
	logic fifo_afull;
	logic [15:0] chout_base;
	logic beat_drop;
	logic beat_sample_keep;
	post_pkg::lanes_t bias_lanes;
	logic wr_en;
	logic [`POST_LANES*`POST_OUT_LANE_W-1:0] wr_data;

	assign beat_fire = in_valid & in_ready;
	assign bias_we = bias_valid & bias_ready;

	post_ctrl post_ctrl_i (
		.clk, .rst_n, .cfg_valid, .cfg_data, .bias_valid, .bias_load_done, .seq_done,
		.fifo_afull, .cfg_ready, .bias_ready, .in_ready, .state(post_status), .row_filter,
		.relu_en, .sample_en, .bias_en, .relu_leaky, .o_ch, .img_h, .img_w, .total_len,
		.chout_len, .start
	);

	chan_seq chan_seq_i (
		.clk, .rst_n, .start, .beat_fire, .row_filter, .img_h, .img_w, .total_len,
		.chout_len, .chout_base, .beat_drop, .beat_sample_keep, .seq_done
	);

	bias_store bias_store_i (
		.clk, .rst_n, .start, .bias_we, .bias_data, .o_ch, .chout_base, .bias_lanes,
		.bias_load_done
	);

	post_pipe post_pipe_i (
		.clk, .rst_n, .beat_fire, .in_data, .beat_drop, .beat_sample_keep, .bias_lanes,
		.bias_en, .relu_en, .relu_leaky, .sample_en, .wr_en, .wr_data
	);

	out_fifo out_fifo_i (
		.clk, .rst_n, .wr_en, .wr_data, .rd_en(post_ready), .rd_valid(post_valid),
		.rd_data(post_data), .afull(fifo_afull)
	);

endmodule

/* sim/post_process_tb.sv */
`include "post_consts.svh"

module post_process_tb;

	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic rst_n;
	logic cfg_valid;
	logic cfg_ready;
	logic [31:0] cfg_data;
	logic bias_valid;
	logic bias_ready;
	logic [`POST_INTER_W-1:0] bias_data;
	logic in_valid;
	logic in_ready;
	logic [`POST_LANES*`POST_INTER_W-1:0] in_data;
	logic post_valid;
	logic post_ready;
	logic [`POST_LANES*`POST_OUT_LANE_W-1:0] post_data;
	post_pkg::post_state_e post_status;

	logic [31:0] seed = 32'h4b1c;	// data and bias words
	logic [31:0] rdy_seed = 32'h4b1c;	// output back-pressure
	logic [4:0] hold = '0;
	logic stalled = 1'b0;
	int cycles = 0;
	int limit = 500;
	logic [15:0] bias_mem [`POST_BIAS_DEPTH];
	logic [`POST_LANES*`POST_OUT_LANE_W-1:0] exp_q [$];

	post_process post_process_i (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// one lane through bias, relu, shift and clamp
	function automatic logic [15:0] expect_lane(input logic [15:0] d, input logic [15:0] b,
			input logic [4:0] fl);
		shortint s;
		int v;
		s = shortint'(d);
		if (fl[3])
			s = s + shortint'(b);	// wraps at 16 bits
		v = s;
		if (fl[1] && v < 0)
			v = fl[4] ? v >>> `POST_LEAKY_SHIFT : 0;
		v = v >>> `POST_FRAC_SHIFT;
		if (v > 127)
			v = 127;
		if (v < -128)
			v = -128;
		return 16'(v);
	endfunction

	// each row holds flags, o_ch, img_w, img_h, total_len and chout_len
	// flag bits 4 down to 0 are relu_leaky, bias_en, sample_en, relu_en and row_filter
	function automatic logic [95:0] run_row(input int r);
		case (r)
			0: return {16'h0a, 16'd32, 16'd4, 16'd3, 16'd2, 16'd16};
			1: return {16'h12, 16'd24, 16'd4, 16'd2, 16'd3, 16'd8};
			2: return {16'h09, 16'd32, 16'd3, 16'd2, 16'd2, 16'd16};
			default: return {16'h0f, 16'd16, 16'd6, 16'd4, 16'd1, 16'd16};
		endcase
	endfunction

	task automatic unpack_row(input int r, output logic [4:0] fl, output int och, w, h, tl, cl);
		logic [95:0] row;
		row = run_row(r);
		fl = row[84:80];
		och = row[79:64];
		w = row[63:48];
		h = row[47:32];
		tl = row[31:16];
		cl = row[15:0];
	endtask

	task automatic stop_on_error(input string why);
		$display("%s", why);
		$display("test failed");
		$fatal(1);
	endtask

	task automatic send_cfg(input logic [31:0] w0, w1, w2);
		logic [31:0] words [3];
		words = '{w0, w1, w2};
		for (int i = 0; i < 3; i++) begin
			cfg_valid = 1'b1;
			cfg_data = words[i];
			assert (cfg_ready) else stop_on_error("cfg_ready low while a config word waits");
			@(negedge clk);
		end
		cfg_valid = 1'b0;
		assert (post_status == post_pkg::LOAD_BIAS && !cfg_ready && bias_ready)
			else stop_on_error("no switch to bias loading after three config words");
	endtask

	task automatic load_bias(input int n);
		for (int i = 0; i < n; i++) begin
			seed = xorshift(seed);
			bias_mem[i] = seed[15:0];
			bias_valid = 1'b1;
			bias_data = seed[15:0];
			assert (bias_ready && post_status == post_pkg::LOAD_BIAS)
				else stop_on_error($sformatf("bias_ready low after %0d of %0d words", i, n));
			@(negedge clk);
		end
		bias_valid = 1'b0;
		assert (!bias_ready && post_status == post_pkg::WORK)
			else stop_on_error("bias loading did not end after o_ch words");
	endtask

	// beat order is group, line, channel block, pixel
	task automatic send_beats(input logic [4:0] fl, input int w, h, tl, cl);
		logic [`POST_LANES*`POST_INTER_W-1:0] d;
		logic [`POST_LANES*`POST_OUT_LANE_W-1:0] exp;
		int base;
		int eff;
		logic keep;
		for (int g = 0; g < tl; g++)
			for (int l = 0; l < h + int'(fl[0]); l++)
				for (int b = 0; b < cl / 8; b++)
					for (int p = 0; p < w; p++) begin
						for (int k = 0; k < 4; k++) begin
							seed = xorshift(seed);
							d[32*k +: 32] = seed;
						end
						base = g * cl + 8 * b;
						eff = l - int'(fl[0]);	// parity after the dropped line
						keep = !(fl[0] && l == 0) && (!fl[2] || (p % 2 == 0 && eff % 2 == 0));
						if (keep) begin
							for (int k = 0; k < `POST_LANES; k++)
								exp[16*k +: 16] = expect_lane(d[16*k +: 16],
									bias_mem[base + k], fl);
							exp_q.push_back(exp);
						end
						in_valid = 1'b1;
						in_data = d;
						while (!in_ready)
							@(negedge clk);
						@(negedge clk);
					end
		in_valid = 1'b0;
		assert (post_status == post_pkg::IDLE && !in_ready && cfg_ready)
			else stop_on_error("not back in idle after the last beat");
	endtask

	// random back-pressure stretches and the output scoreboard
	always @(negedge clk) begin
		if (hold == 0) begin
			rdy_seed = xorshift(rdy_seed);
			post_ready = rdy_seed[0];
			hold = rdy_seed[8:4];
		end else begin
			hold = hold - 5'd1;
		end
		if (post_status == post_pkg::WORK && !in_ready)
			stalled = 1'b1;
		if (post_valid && post_ready) begin
			assert (exp_q.size() != 0) else stop_on_error("output beat with none expected");
			assert (post_data === exp_q[0])
				else stop_on_error($sformatf("mismatch post_data exp %h got %h",
					exp_q[0], post_data));
			void'(exp_q.pop_front());
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit)
			stop_on_error($sformatf("timeout after %0d cycles", cycles));
	end

	initial begin
		logic [4:0] fl;
		int och, w, h, tl, cl;
		rst_n = 1'b0;
		cfg_valid = 1'b0;
		cfg_data = '0;
		bias_valid = 1'b0;
		bias_data = '0;
		in_valid = 1'b0;
		in_data = '0;
		post_ready = 1'b0;
		for (int r = 0; r < 4; r++) begin
			unpack_row(r, fl, och, w, h, tl, cl);
			limit += 4 * tl * (h + int'(fl[0])) * (cl / 8) * w;
		end
		repeat (4) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		assert (post_status == post_pkg::IDLE && cfg_ready && !bias_ready && !in_ready
				&& !post_valid)
			else stop_on_error("wrong status or ready levels after reset");
		for (int r = 0; r < 4; r++) begin
			unpack_row(r, fl, och, w, h, tl, cl);
			send_cfg({8'd0, och[15:0], 3'd0, fl}, {8'd0, h[11:0], w[11:0]},
				{tl[15:0], cl[15:0]});
			load_bias(och);
			send_beats(fl, w, h, tl, cl);
			while (exp_q.size() != 0)
				@(negedge clk);
		end
		repeat (10) @(negedge clk);	// catch stray beats
		if (stalled) begin
			$display("test passed");
			$finish;
		end else begin
			stop_on_error("in_ready never fell under back-pressure");
		end
	end

endmodule

/* post_process.f */
+incdir+logic
logic/post_pkg.sv
logic/post_ctrl.sv
logic/chan_seq.sv
logic/bias_store.sv
logic/post_pipe.sv
logic/out_fifo.sv
logic/post_process.sv
sim/post_process_tb.sv
